// File: common/board_defs.svh
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// board geometry
`define BOARD_TILES   10
`define TILE_PIX      32
`define THEM_X0       320     // us board sits at x = 0

// 640x480 raster, pixel clock is clk / PIX_DIV
`define PIX_DIV       4
`define H_TOTAL       800
`define H_ACTIVE      640
`define H_SYNC_START  656
`define H_SYNC_LEN    96
`define V_TOTAL       525
`define V_ACTIVE      480
`define V_SYNC_START  490
`define V_SYNC_LEN    2
`define RENDER_DELAY  8       // clocks from counters to vga pins

`define TICK_PERIOD   1000    // clocks between interrupts, raise for hardware

// 12-bit palette, rgb 4:4:4
`define COL_EMPTY     12'h00F
`define COL_SHIP      12'h888
`define COL_HIT       12'hF00
`define COL_MISS      12'hFFF
`define COL_GHOST     12'h0F0
`define COL_CURSOR    12'hFF0
`define COL_BLACK     12'h000

`endif

// File: common/boardPkg.sv
package boardPkg;

    ////////////////////////////////////////////////////////////
    // board tile and bus types
    ////////////////////////////////////////////////////////////

    // state of one board square, as stored in the tile memories
    typedef enum logic [1:0] {
        tileEmpty = 2'd0,  // open water
        tileShip  = 2'd1,  // own ship, not yet struck
        tileHit   = 2'd2,
        tileMiss  = 2'd3
    } tileT;

    // port ids seen on the processor bus
    typedef enum logic [7:0] {
        portCursor    = 8'h00, // r/w
        portWriteAddr = 8'h01, // w, address for the next tile write
        portTileUs    = 8'h02, // w
        portTileThem  = 8'h03, // w
        portReadTile  = 8'h04, // r, us tile under the cursor
        portOrient    = 8'h05, // w
        portShipLen   = 8'h06  // w
    } portAddrT;

    typedef enum logic {
        orientHoriz = 1'b0,
        orientVert  = 1'b1
    } orientT;

    // cursor position, doubles as tile memory address
    typedef struct packed {
        logic [3:0] row;
        logic [3:0] col;
    } cursorT;

    // what a pixel shows, resolved to RGB by the palette
    typedef enum logic [2:0] {
        roleBlack, roleEmpty, roleShip, roleHit, roleMiss, roleGhost, roleCursor
    } colourRoleT;

endpackage

// File: common/boardIfs.sv
`timescale 1ns/1ps

// single-strobe write into one of the two tile memories
interface tileWriteIf;
    logic             wrEn;    // one clock pulse per write
    logic             wrThem;  // 0 = us board, 1 = them board
    boardPkg::cursorT wrAddr;
    boardPkg::tileT   wrTile;

    modport source (output wrEn, output wrThem, output wrAddr, output wrTile);
    modport store  (input wrEn, input wrThem, input wrAddr, input wrTile);
endinterface

// raster position and sync from the timing generator
interface pixelIf;
    logic       pixEn;   // one clk in PIX_DIV
    logic [9:0] pixX;
    logic [9:0] pixY;
    logic       videoOn;
    logic       hSync;   // active low
    logic       vSync;   // active low

    modport timing (
        output pixEn, output pixX, output pixY,
        output videoOn, output hSync, output vSync
    );
    modport render (
        input pixEn, input pixX, input pixY,
        input videoOn, input hSync, input vSync
    );
endinterface

// File: rtl/tileStore.sv
`timescale 1ns/1ps
`include "board_defs.svh"

module tileStore (
    input  logic             clk,
    tileWriteIf.store        tileWr,
    input  boardPkg::cursorT cursor,
    output boardPkg::tileT   cursorTile,  // registered read for the processor
    input  boardPkg::cursorT usVidAddr,
    input  boardPkg::cursorT themVidAddr,
    output boardPkg::tileT   usVidTile,   // registered video reads
    output boardPkg::tileT   themVidTile
);

    boardPkg::tileT usMem   [256];
    boardPkg::tileT themMem [256];

    // both boards power up as open water
    initial begin
        for (int i = 0; i < 256; i++) begin
            usMem[i]   = boardPkg::tileEmpty;
            themMem[i] = boardPkg::tileEmpty;
        end
    end

    always @(posedge clk) begin
        if (tileWr.wrEn && !tileWr.wrThem) usMem[tileWr.wrAddr]   <= tileWr.wrTile;
        if (tileWr.wrEn &&  tileWr.wrThem) themMem[tileWr.wrAddr] <= tileWr.wrTile;
        cursorTile  <= usMem[cursor];      // processor port of the us board
        usVidTile   <= usMem[usVidAddr];   // video ports, read every clock
        themVidTile <= themMem[themVidAddr];
    end

    // processor must only address squares that exist on the board
    aWrInBoard: assert property (@(posedge clk)
        tileWr.wrEn |-> (tileWr.wrAddr.row < `BOARD_TILES) && (tileWr.wrAddr.col < `BOARD_TILES));

endmodule

// File: picoPort/picoPortRegs.sv
`timescale 1ns/1ps

module picoPortRegs (
    input  logic             clk,
    input  logic             rstN,
    input  logic [7:0]       portId,
    input  logic [7:0]       outPort,
    input  logic             writeStrobe,
    input  logic             readStrobe,
    output logic [7:0]       inPort,
    tileWriteIf.source       tileWr,
    input  boardPkg::tileT   cursorTile,
    output boardPkg::cursorT cursor,
    output boardPkg::orientT orient,
    output logic [3:0]       shipLen
);

    boardPkg::cursorT writeAddr;   // target of the next tile write
    logic [7:0]       readSel;     // port id latched by the read strobe
    logic             tileWrite;

    assign tileWrite = writeStrobe &&
                       (portId == boardPkg::portTileUs || portId == boardPkg::portTileThem);

    ////////////////////////////////////////////////////////////
    // write decode
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cursor      <= '0;
            writeAddr   <= '0;
            orient      <= boardPkg::orientHoriz;
            shipLen     <= '0;
            tileWr.wrEn <= 1'b0;
        end else begin
            tileWr.wrEn <= tileWrite;  // memory write lands one clock later
            if (writeStrobe) begin
                case (portId)
                    boardPkg::portCursor:    cursor    <= outPort;
                    boardPkg::portWriteAddr: writeAddr <= outPort;
                    boardPkg::portOrient:    orient    <= boardPkg::orientT'(outPort[0]);
                    boardPkg::portShipLen:   shipLen   <= outPort[3:0];
                    default: ;             // tile ports handled below
                endcase
            end
        end
    end

    // write payload, only meaningful while wrEn is high
    always_ff @(posedge clk) begin
        if (tileWrite) begin
            tileWr.wrAddr <= writeAddr;
            tileWr.wrTile <= boardPkg::tileT'(outPort[1:0]);
            tileWr.wrThem <= (portId == boardPkg::portTileThem);
        end
    end

    ////////////////////////////////////////////////////////////
    // read mux, one clock behind the sampled port id
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            readSel <= 8'hFF;              // no port, reads as zero
            inPort  <= '0;
        end else begin
            if (readStrobe) readSel <= portId;
            case (readSel)
                boardPkg::portCursor:   inPort <= cursor;
                boardPkg::portReadTile: inPort <= {6'b0, cursorTile};
                default:                inPort <= '0;
            endcase
        end
    end

    // the processor cannot issue back-to-back OUTPUTs
    aWrPulse: assert property (@(posedge clk) disable iff (!rstN)
        tileWr.wrEn |=> !tileWr.wrEn);

endmodule

// File: picoPort/tickInterrupt.sv
`timescale 1ns/1ps
`include "board_defs.svh"

module tickInterrupt (
    input  logic clk,
    input  logic rstN,
    input  logic interruptAck,  // one clock pulse from the processor
    output logic interrupt      // level, held until acked
);

    localparam int CntW = $clog2(`TICK_PERIOD);

    logic [CntW-1:0] tickCnt;
    logic            tick;

    assign tick = (tickCnt == CntW'(`TICK_PERIOD - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            tickCnt   <= '0;
            interrupt <= 1'b0;
        end else begin
            tickCnt <= tick ? '0 : tickCnt + 1'b1;  // free running
            if (interruptAck)  interrupt <= 1'b0;   // ack wins, a pending tick is dropped
            else if (tick)     interrupt <= 1'b1;
        end
    end

    aIrqDrop: assert property (@(posedge clk) disable iff (!rstN)
        $fell(interrupt) |-> $past(interruptAck));

endmodule

// File: video/displayTiming.sv
`timescale 1ns/1ps
`include "board_defs.svh"

module displayTiming (
    input  logic   clk,
    input  logic   rstN,
    pixelIf.timing pix
);

    localparam int DivW = $clog2(`PIX_DIV);

    logic [DivW-1:0] divCnt;
    logic [9:0]      hCnt, vCnt;
    logic            lineEnd;

    assign pix.pixEn = (divCnt == '0);   // high on the first clock out of reset
    assign lineEnd   = (hCnt == 10'(`H_TOTAL - 1));

    ////////////////////////////////////////////////////////////
    // pixel divider and raster counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            divCnt <= '0;
            hCnt   <= '0;
            vCnt   <= '0;
        end else begin
            divCnt <= (divCnt == DivW'(`PIX_DIV - 1)) ? '0 : divCnt + 1'b1;
            if (pix.pixEn) begin
                hCnt <= lineEnd ? '0 : hCnt + 1'b1;
                if (lineEnd)
                    vCnt <= (vCnt == 10'(`V_TOTAL - 1)) ? '0 : vCnt + 1'b1;
            end
        end
    end

    assign pix.pixX = hCnt;
    assign pix.pixY = vCnt;

    // sync and blanking straight off the counters
    assign pix.videoOn = (hCnt < `H_ACTIVE) && (vCnt < `V_ACTIVE);
    assign pix.hSync   = !((hCnt >= `H_SYNC_START) && (hCnt < `H_SYNC_START + `H_SYNC_LEN));
    assign pix.vSync   = !((vCnt >= `V_SYNC_START) && (vCnt < `V_SYNC_START + `V_SYNC_LEN));

    aXRange: assert property (@(posedge clk) disable iff (!rstN) hCnt < `H_TOTAL);

endmodule

// File: video/boardRenderer.sv
`timescale 1ns/1ps
`include "board_defs.svh"

module boardRenderer (
    input  logic             clk,
    input  logic             rstN,
    pixelIf.render           pix,
    input  boardPkg::cursorT cursor,
    input  boardPkg::orientT orient,
    input  logic [3:0]       shipLen,
    output boardPkg::cursorT usVidAddr,
    output boardPkg::cursorT themVidAddr,
    input  boardPkg::tileT   usVidTile,
    input  boardPkg::tileT   themVidTile,
    output logic [3:0]       vgaRed,
    output logic [3:0]       vgaGreen,
    output logic [3:0]       vgaBlue,
    output logic             hSync,
    output logic             vSync
);

    localparam int BoardPix  = `BOARD_TILES * `TILE_PIX;
    localparam int PipeDepth = `RENDER_DELAY / `PIX_DIV;  // pixel stages after the role reg

    logic [9:0]           themX;
    logic [4:0]           tileRow, usCol, themCol;
    logic                 inUs, inThem, onGhost, onCursor;
    boardPkg::colourRoleT role, roleQ;
    logic                 hSyncQ, vSyncQ;
    logic [11:0]          colPipe [PipeDepth];
    logic                 hPipe   [PipeDepth];
    logic                 vPipe   [PipeDepth];

    function automatic boardPkg::colourRoleT tileRole(boardPkg::tileT t);
        case (t)
            boardPkg::tileShip: return boardPkg::roleShip;
            boardPkg::tileHit:  return boardPkg::roleHit;
            boardPkg::tileMiss: return boardPkg::roleMiss;
            default:            return boardPkg::roleEmpty;
        endcase
    endfunction

    function automatic logic [11:0] palette(boardPkg::colourRoleT r);
        case (r)
            boardPkg::roleEmpty:  return `COL_EMPTY;
            boardPkg::roleShip:   return `COL_SHIP;
            boardPkg::roleHit:    return `COL_HIT;
            boardPkg::roleMiss:   return `COL_MISS;
            boardPkg::roleGhost:  return `COL_GHOST;
            boardPkg::roleCursor: return `COL_CURSOR;
            default:              return `COL_BLACK;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // board / tile lookup for the current pixel
    ////////////////////////////////////////////////////////////
    always_comb begin
        themX   = pix.pixX - 10'(`THEM_X0);
        tileRow = 5'(pix.pixY / `TILE_PIX);
        usCol   = 5'(pix.pixX / `TILE_PIX);
        themCol = 5'(themX / `TILE_PIX);
        inUs    = pix.videoOn && (pix.pixX < BoardPix) && (pix.pixY < BoardPix);
        inThem  = pix.videoOn && (pix.pixX >= `THEM_X0) && (pix.pixX < `THEM_X0 + BoardPix)
                  && (pix.pixY < BoardPix);
        usVidAddr   = {tileRow[3:0], usCol[3:0]};   // memory reads every clk
        themVidAddr = {tileRow[3:0], themCol[3:0]};
        // ghost ship runs from the cursor along the chosen axis
        if (orient == boardPkg::orientHoriz)
            onGhost = (tileRow == {1'b0, cursor.row}) && (usCol >= {1'b0, cursor.col})
                      && (usCol < {1'b0, cursor.col} + {1'b0, shipLen});
        else
            onGhost = (usCol == {1'b0, cursor.col}) && (tileRow >= {1'b0, cursor.row})
                      && (tileRow < {1'b0, cursor.row} + {1'b0, shipLen});
        onCursor = (tileRow == {1'b0, cursor.row}) && (themCol == {1'b0, cursor.col});
        if (inUs)        role = onGhost ? boardPkg::roleGhost : tileRole(usVidTile);
        else if (inThem) role = onCursor ? boardPkg::roleCursor : tileRole(themVidTile);
        else             role = boardPkg::roleBlack;  // blanking and below the boards
    end

    ////////////////////////////////////////////////////////////
    // pixel pipeline, advances once per pixel
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            roleQ  <= boardPkg::roleBlack;
            hSyncQ <= 1'b1;
            vSyncQ <= 1'b1;
            for (int i = 0; i < PipeDepth; i++) begin
                colPipe[i] <= `COL_BLACK;
                hPipe[i]   <= 1'b1;
                vPipe[i]   <= 1'b1;
            end
        end else if (pix.pixEn) begin
            roleQ      <= role;    // tile data has settled by the last clk of the pixel
            hSyncQ     <= pix.hSync;
            vSyncQ     <= pix.vSync;
            colPipe[0] <= palette(roleQ);
            hPipe[0]   <= hSyncQ;  // syncs follow the colour stage for stage
            vPipe[0]   <= vSyncQ;
            for (int i = 1; i < PipeDepth; i++) begin
                colPipe[i] <= colPipe[i-1];
                hPipe[i]   <= hPipe[i-1];
                vPipe[i]   <= vPipe[i-1];
            end
        end
    end

    assign {vgaRed, vgaGreen, vgaBlue} = colPipe[PipeDepth-1];
    assign hSync = hPipe[PipeDepth-1];
    assign vSync = vPipe[PipeDepth-1];

endmodule

// File: rtl/boardTop.sv
`timescale 1ns/1ps

module boardTop (
    input  logic       clk,
    input  logic       rstN,
    input  logic [7:0] portId,
    input  logic [7:0] outPort,      // byte from the processor
    input  logic       writeStrobe,
    input  logic       readStrobe,
    input  logic       interruptAck,
    output logic [7:0] inPort,       // byte to the processor
    output logic       interrupt,
    output logic [3:0] vgaRed,
    output logic [3:0] vgaGreen,
    output logic [3:0] vgaBlue,
    output logic       hSync,
    output logic       vSync
);

    boardPkg::cursorT cursor;
    boardPkg::orientT orient;
    logic [3:0]       shipLen;
    boardPkg::tileT   cursorTile;    // us tile under the cursor
    boardPkg::cursorT usVidAddr, themVidAddr;
    boardPkg::tileT   usVidTile, themVidTile;

    tileWriteIf tileWr ();
    pixelIf     pix ();

    ////////////////////////////////////////////////////////////
    // processor side
    ////////////////////////////////////////////////////////////
    picoPortRegs portRegs (
        .clk, .rstN, .portId, .outPort, .writeStrobe, .readStrobe, .inPort,
        .tileWr (tileWr.source),
        .cursorTile, .cursor, .orient, .shipLen
    );

    tickInterrupt tickIrq (.clk, .rstN, .interruptAck, .interrupt);

    tileStore tiles (
        .clk,
        .tileWr (tileWr.store),
        .cursor, .cursorTile, .usVidAddr, .themVidAddr, .usVidTile, .themVidTile
    );

    ////////////////////////////////////////////////////////////
    // video side
    ////////////////////////////////////////////////////////////
    displayTiming rasterGen (.clk, .rstN, .pix (pix.timing));

    boardRenderer renderer (
        .clk, .rstN,
        .pix (pix.render),
        .cursor, .orient, .shipLen, .usVidAddr, .themVidAddr, .usVidTile, .themVidTile,
        .vgaRed, .vgaGreen, .vgaBlue, .hSync, .vSync
    );

endmodule

// File: testbench/boardTopTb.sv
`timescale 1ns/1ps
`include "board_defs.svh"

module boardTopTb;

    localparam int HPulse      = `H_SYNC_LEN * `PIX_DIV;  // clocks
    localparam int HPeriod     = `H_TOTAL * `PIX_DIV;
    localparam int VPulse      = `V_SYNC_LEN * HPeriod;
    localparam int FrameClks   = `V_TOTAL * HPeriod;
    localparam int FramePix    = `H_TOTAL * `V_TOTAL;
    localparam int TimeoutClks = 2 * FrameClks + 20000;   // two frames plus bus traffic

    logic        clk, rstN;
    logic [7:0]  portId, outPort, inPort;
    logic        writeStrobe, readStrobe, interruptAck, interrupt;
    logic [3:0]  vgaRed, vgaGreen, vgaBlue;
    logic        hSync, vSync;
    logic [11:0] rgb;

    int          seed = 32'ha55417e6;
    int          edgeNo = 0;        // sampled value is the edge count since reset release
    int          cycles = 0;
    int          curTest = 0;
    int          checkCnt [5] = '{default: 0};
    int          failCnt  [5] = '{default: 0};
    logic [7:0]  expRead = 8'h00;
    logic [1:0]  readPipe = 2'b00;  // read strobe, two edges late
    logic        prevH, prevV, hFellOnce, vFellOnce;
    int          hLowCnt, vLowCnt, hPeriodCnt, vPeriodCnt;
    int unsigned rnd;
    int          row, col, totalChecks, totalFails, unreached;
    logic [1:0]  tileVal;
    logic [7:0]  addr;

    // pixel probes, kept in raster order
    int          pEdge [32];
    logic [11:0] pCol  [32];
    int          pTest [32];
    int          nProbes = 0;
    int          pIdx = 0;
    logic        probeDue;
    logic [11:0] probeExp;
    int          probeNum;

    assign rgb      = {vgaRed, vgaGreen, vgaBlue};
    assign probeDue = (pIdx < nProbes) && (edgeNo == pEdge[pIdx]);
    assign probeExp = pCol[pIdx];
    assign probeNum = pTest[pIdx];

    boardTop i_dut (
        .clk, .rstN, .portId, .outPort, .writeStrobe, .readStrobe, .interruptAck,
        .inPort, .interrupt, .vgaRed, .vgaGreen, .vgaBlue, .hSync, .vSync
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic string testName(input int t);
        case (t)
            0:       return "tileRoundTrip";
            1:       return "interrupt";
            2:       return "rasterTiming";
            3:       return "boardColours";
            default: return "blanking";
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // bus tasks
    ////////////////////////////////////////////////////////////
    task automatic busWrite(input logic [7:0] id, input logic [7:0] data);
        @(posedge clk);
        portId      <= id;
        outPort     <= data;
        writeStrobe <= 1'b1;
        @(posedge clk);
        writeStrobe <= 1'b0;          // one clock strobe
    endtask

    task automatic busRead(input logic [7:0] id, input logic [7:0] expected);
        @(posedge clk);
        portId     <= id;
        readStrobe <= 1'b1;
        expRead    <= expected;
        @(posedge clk);
        readStrobe <= 1'b0;
        repeat (2) @(posedge clk);    // inPort check lands here
    endtask

    task automatic writeTile(input logic them, input int r, input int c, input logic [1:0] t);
        busWrite(boardPkg::portWriteAddr, {r[3:0], c[3:0]});
        busWrite(them ? boardPkg::portTileThem : boardPkg::portTileUs, {6'b0, t});
    endtask

    // colour of pixel n is held from t0 + 4n, probe the middle of that window
    task automatic addProbe(input int x, input int y, input logic [11:0] c, input int t);
        pEdge[nProbes] = `RENDER_DELAY + 3 + `PIX_DIV * (FramePix + y * `H_TOTAL + x);
        pCol[nProbes]  = c;
        pTest[nProbes] = t;
        nProbes++;
    endtask

    task automatic report(input int t);
        @(posedge clk);               // let the last check of the test settle
        if (checkCnt[t] == 0) begin
            $display("%s: no checks were reached", testName(t));
            unreached++;
        end else begin
            $display("%s: %0d passed, %0d failed", testName(t),
                     checkCnt[t] - failCnt[t], failCnt[t]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // monitors and check counting
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        cycles   <= cycles + 1;
        edgeNo   <= rstN ? edgeNo + 1 : 1;
        readPipe <= {readPipe[0], readStrobe};
        if (probeDue) pIdx <= pIdx + 1;
        if (!rstN) begin
            prevH      <= 1'b1;
            prevV      <= 1'b1;
            hFellOnce  <= 1'b0;
            vFellOnce  <= 1'b0;
            hLowCnt    <= 0;
            vLowCnt    <= 0;
            hPeriodCnt <= 0;
            vPeriodCnt <= 0;
        end else begin
            prevH      <= hSync;
            prevV      <= vSync;
            hLowCnt    <= hSync ? 0 : hLowCnt + 1;       // length of the current low run
            vLowCnt    <= vSync ? 0 : vLowCnt + 1;
            hPeriodCnt <= (!hSync && prevH) ? 1 : hPeriodCnt + 1;
            vPeriodCnt <= (!vSync && prevV) ? 1 : vPeriodCnt + 1;
            if (!hSync && prevH) hFellOnce <= 1'b1;
            if (!vSync && prevV) vFellOnce <= 1'b1;
            // same triggers as the assertions below
            if (readPipe[1]) checkCnt[0]++;
            if (edgeNo <= `TICK_PERIOD) checkCnt[1]++;
            if (edgeNo == `TICK_PERIOD) checkCnt[1]++;
            if (interruptAck) checkCnt[1]++;
            if (curTest == 1 && interrupt && !interruptAck) checkCnt[1]++;
            if (edgeNo <= `RENDER_DELAY) checkCnt[2]++;
            if (hSync && !prevH) checkCnt[2]++;
            if (vSync && !prevV) checkCnt[2]++;
            if (!hSync && prevH && hFellOnce) checkCnt[2]++;
            if (!vSync && prevV && vFellOnce) checkCnt[2]++;
            if (probeDue) checkCnt[probeNum]++;
        end
    end

    always @(posedge clk) begin
        if (cycles >= TimeoutClks) begin
            $display("timeout: run did not finish within %0d clocks", TimeoutClks);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    aReadBack: assert property (@(posedge clk) disable iff (!rstN)
        readPipe[1] |-> inPort == expRead)
        else begin
            failCnt[0]++;
            $display("Mismatch %s: expected %0h, actual %0h", testName(0),
                     $sampled(expRead), $sampled(inPort));
        end

    aIrqQuiet: assert property (@(posedge clk) disable iff (!rstN)
        edgeNo <= `TICK_PERIOD |-> !interrupt)
        else begin
            failCnt[1]++;
            $display("interrupt: interrupt rose before the first tick period ended");
        end

    aIrqFirst: assert property (@(posedge clk) disable iff (!rstN)
        edgeNo == `TICK_PERIOD |=> interrupt)
        else begin
            failCnt[1]++;
            $display("interrupt: interrupt did not rise one tick period after reset");
        end

    aIrqAck: assert property (@(posedge clk) disable iff (!rstN)
        interruptAck |=> !interrupt)
        else begin
            failCnt[1]++;
            $display("interrupt: interrupt still high one clock after the acknowledge");
        end

    aIrqHold: assert property (@(posedge clk) disable iff (!rstN)
        curTest == 1 && interrupt && !interruptAck |=> interrupt)
        else begin
            failCnt[1]++;
            $display("interrupt: interrupt dropped without an acknowledge");
        end

    aSyncIdle: assert property (@(posedge clk) disable iff (!rstN)
        edgeNo <= `RENDER_DELAY |-> hSync && vSync)
        else begin
            failCnt[2]++;
            $display("rasterTiming: a sync was active right after reset");
        end

    aHPulse: assert property (@(posedge clk) disable iff (!rstN)
        $rose(hSync) |-> hLowCnt == HPulse)
        else begin
            failCnt[2]++;
            $display("Mismatch %s hSync low clocks: expected %0d, actual %0d",
                     testName(2), HPulse, $sampled(hLowCnt));
        end

    aHPeriod: assert property (@(posedge clk) disable iff (!rstN)
        $fell(hSync) && hFellOnce |-> hPeriodCnt == HPeriod)
        else begin
            failCnt[2]++;
            $display("Mismatch %s hSync period: expected %0d, actual %0d",
                     testName(2), HPeriod, $sampled(hPeriodCnt));
        end

    aVPulse: assert property (@(posedge clk) disable iff (!rstN)
        $rose(vSync) |-> vLowCnt == VPulse)
        else begin
            failCnt[2]++;
            $display("Mismatch %s vSync low clocks: expected %0d, actual %0d",
                     testName(2), VPulse, $sampled(vLowCnt));
        end

    aVPeriod: assert property (@(posedge clk) disable iff (!rstN)
        $fell(vSync) && vFellOnce |-> vPeriodCnt == FrameClks)
        else begin
            failCnt[2]++;
            $display("Mismatch %s vSync period: expected %0d, actual %0d",
                     testName(2), FrameClks, $sampled(vPeriodCnt));
        end

    aPixel: assert property (@(posedge clk) disable iff (!rstN)
        probeDue |-> rgb == probeExp)
        else begin
            failCnt[$sampled(probeNum)]++;
            $display("Mismatch %s: expected %03h, actual %03h", testName($sampled(probeNum)),
                     $sampled(probeExp), $sampled(rgb));
        end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    initial begin
        rstN         = 1'b0;
        portId       = 8'h00;
        outPort      = 8'h00;
        writeStrobe  = 1'b0;
        readStrobe   = 1'b0;
        interruptAck = 1'b0;
        unreached    = 0;

        // frame 1 probes, raster order
        addProbe(16, 16, `COL_SHIP, 3);
        addProbe(700, 16, `COL_BLACK, 4);            // horizontal blanking
        addProbe(368, 48, `COL_HIT, 3);
        for (int c = 2; c < 6; c++) addProbe(c * 32 + 16, 112, `COL_GHOST, 3);
        addProbe(208, 112, `COL_HIT, 3);             // one past the ghost ship
        addProbe(400, 112, `COL_CURSOR, 3);
        addProbe(432, 112, `COL_SHIP, 3);
        addProbe(240, 176, `COL_MISS, 3);
        addProbe(464, 272, `COL_MISS, 3);
        addProbe(304, 304, `COL_EMPTY, 3);
        addProbe(799, 304, `COL_BLACK, 4);
        addProbe(100, 330, `COL_BLACK, 4);           // below the boards
        addProbe(500, 479, `COL_BLACK, 4);
        addProbe(320, 500, `COL_BLACK, 4);           // vertical blanking

        repeat (16) @(posedge clk);
        rstN <= 1'b1;

        // random us tiles read back through the cursor
        for (int i = 0; i < 10; i++) begin
            rnd     = $random(seed);
            row     = rnd % 10;
            rnd     = $random(seed);
            col     = rnd % 10;
            rnd     = $random(seed);
            tileVal = 2'(rnd % 4);
            addr    = {row[3:0], col[3:0]};
            writeTile(1'b0, row, col, tileVal);
            busWrite(boardPkg::portCursor, addr);
            repeat (3) @(posedge clk);
            busRead(boardPkg::portReadTile, {6'b0, tileVal});
            busRead(boardPkg::portCursor, addr);
        end
        report(0);

        // known boards for frame 1
        curTest <= 3;
        writeTile(1'b0, 0, 0, boardPkg::tileShip);
        writeTile(1'b0, 5, 7, boardPkg::tileMiss);
        writeTile(1'b0, 9, 9, boardPkg::tileEmpty);
        writeTile(1'b0, 3, 6, boardPkg::tileHit);
        writeTile(1'b0, 3, 3, boardPkg::tileMiss);    // hidden under the ghost
        writeTile(1'b1, 3, 2, boardPkg::tileShip);    // hidden under the cursor
        writeTile(1'b1, 3, 3, boardPkg::tileShip);
        writeTile(1'b1, 1, 1, boardPkg::tileHit);
        writeTile(1'b1, 8, 4, boardPkg::tileMiss);
        busWrite(boardPkg::portCursor, 8'h32);
        busWrite(boardPkg::portOrient, 8'h00);
        busWrite(boardPkg::portShipLen, 8'h04);

        // interrupt held past a lost tick, then acked
        curTest <= 1;
        while (!interrupt) @(posedge clk);
        repeat (1500) @(posedge clk);
        interruptAck <= 1'b1;
        @(posedge clk);
        interruptAck <= 1'b0;
        repeat (4) @(posedge clk);
        report(1);

        curTest <= 2;
        while (pIdx < nProbes) @(posedge clk);
        report(2);
        report(3);
        report(4);

        totalChecks = 0;
        totalFails  = 0;
        for (int t = 0; t < 5; t++) begin
            totalChecks += checkCnt[t];
            totalFails  += failCnt[t];
        end
        $display("tests: 5, checks: %0d, failed: %0d, tests without checks: %0d",
                 totalChecks, totalFails, unreached);
        if (totalFails == 0 && unreached == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+common
common/boardPkg.sv
common/boardIfs.sv
rtl/tileStore.sv
picoPort/picoPortRegs.sv
picoPort/tickInterrupt.sv
video/displayTiming.sv
video/boardRenderer.sv
rtl/boardTop.sv
testbench/boardTopTb.sv

// File: runSim.sh
#!/bin/sh
# build and run the board testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module boardTopTb \
    -f vlog.f -o boardTopTbSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/boardTopTbSim)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1
